// File: ray_tracer_top.f
rtl/trace_cfg_pkg.sv
rtl/trace_types_pkg.sv
rtl/trace_if.sv
rtl/ray_fifo.sv
rtl/triangle_mem.sv
rtl/ray_streamer.sv
rtl/edge_hit_test.sv
rtl/hit_accumulate.sv
rtl/ray_tracer_top.sv
test/ray_tracer_tb.sv

// File: rtl/edge_hit_test.sv
`default_nettype none

module edge_hit_test (
    input  logic clock,
    input  logic reset,
    pair_if.dst  pair,
    hit_if.src   hit
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    logic                    s1_valid;
    logic                    s1_last;
    logic [RAY_ID_BITS-1:0]  s1_ray_id;
    logic [TRI_ID_BITS-1:0]  s1_tri_id;
    logic [DEPTH_BITS-1:0]   s1_depth;
    logic signed [EDGE_BITS:0] s1_edge [3];

    // >= 0 when p lies left of or on a->b
    function automatic logic signed [EDGE_BITS:0] edge_fn(vertex_t a, vertex_t b, ray_t p);
        logic signed [COORD_BITS:0]  dx_ab;
        logic signed [COORD_BITS:0]  dy_ab;
        logic signed [COORD_BITS:0]  dx_ap;
        logic signed [COORD_BITS:0]  dy_ap;
        logic signed [EDGE_BITS-1:0] prod_0;
        logic signed [EDGE_BITS-1:0] prod_1;
        dx_ab  = (COORD_BITS+1)'(b.x) - (COORD_BITS+1)'(a.x);
        dy_ab  = (COORD_BITS+1)'(b.y) - (COORD_BITS+1)'(a.y);
        dx_ap  = (COORD_BITS+1)'(p.x) - (COORD_BITS+1)'(a.x);
        dy_ap  = (COORD_BITS+1)'(p.y) - (COORD_BITS+1)'(a.y);
        prod_0 = EDGE_BITS'(dx_ab) * EDGE_BITS'(dy_ap);
        prod_1 = EDGE_BITS'(dy_ab) * EDGE_BITS'(dx_ap);
        return (EDGE_BITS+1)'(prod_0) - (EDGE_BITS+1)'(prod_1);
    endfunction

    // stage 1, edge values
    always_ff @(posedge clock) begin
        s1_ray_id  <= pair.ray_id;
        s1_tri_id  <= pair.tri_id;
        s1_depth   <= pair.triangle.depth;
        s1_edge[0] <= edge_fn(pair.triangle.v0, pair.triangle.v1, pair.ray);
        s1_edge[1] <= edge_fn(pair.triangle.v1, pair.triangle.v2, pair.ray);
        s1_edge[2] <= edge_fn(pair.triangle.v2, pair.triangle.v0, pair.ray);
    end

    // stage 2, sign test, edge points count as covered
    always_ff @(posedge clock) begin
        hit.ray_id <= s1_ray_id;
        hit.tri_id <= s1_tri_id;
        hit.depth  <= s1_depth;
        hit.hit    <= !s1_edge[0][EDGE_BITS] && !s1_edge[1][EDGE_BITS] &&
                      !s1_edge[2][EDGE_BITS];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            hit.valid <= 1'b0;
            hit.last  <= 1'b0;
        end else begin
            s1_valid  <= pair.valid;
            s1_last   <= pair.last;
            hit.valid <= s1_valid;
            hit.last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hit_accumulate.sv
`default_nettype none

module hit_accumulate (
    input  logic                        clock,
    input  logic                        reset,
    hit_if.dst                          hit,
    output logic                        result_wr,
    output trace_types_pkg::result_t    result
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    logic                    best_hit;
    logic [TRI_ID_BITS-1:0]  best_tri_id;
    logic [DEPTH_BITS-1:0]   best_depth;
    logic                    take;
    logic                    nxt_hit;
    logic [TRI_ID_BITS-1:0]  nxt_tri_id;
    logic [DEPTH_BITS-1:0]   nxt_depth;

    // strict compare, so ties keep the lower tri_id
    assign take       = hit.hit && (!best_hit || hit.depth < best_depth);
    assign nxt_hit    = take || best_hit;
    assign nxt_tri_id = take ? hit.tri_id : best_tri_id;
    assign nxt_depth  = take ? hit.depth : best_depth;

    always_ff @(posedge clock) begin
        if (reset) begin
            best_hit    <= 1'b0;
            best_tri_id <= '0;
            best_depth  <= '0;
            result_wr   <= 1'b0;
        end else begin
            result_wr <= hit.valid && hit.last;
            if (hit.valid) begin
                // cleared best gives the zero fields of a miss
                best_hit    <= hit.last ? 1'b0 : nxt_hit;
                best_tri_id <= hit.last ? '0 : nxt_tri_id;
                best_depth  <= hit.last ? '0 : nxt_depth;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hit.valid && hit.last) begin
            result.ray_id <= hit.ray_id;
            result.hit    <= nxt_hit;
            result.tri_id <= nxt_tri_id;
            result.depth  <= nxt_depth;
        end
    end

    a_single_write: assert property (@(posedge clock) disable iff (reset)
        result_wr |=> !result_wr);

endmodule

`default_nettype wire

// File: rtl/ray_fifo.sv
`default_nettype none

module ray_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    output logic     almost_full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    payload_t                    mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]    wr_ptr;
    logic [$clog2(DEPTH)-1:0]    rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]  count;
    logic                        do_wr;
    logic                        do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full        = count == DEPTH;
    assign almost_full = count >= DEPTH - 2;
    assign empty       = count == 0;

    // show-ahead output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        wr_en |-> !full);

    a_no_read_when_empty: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> !empty);

endmodule

`default_nettype wire

// File: rtl/ray_streamer.sv
`default_nettype none

module ray_streamer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  ray_empty,
    output logic                                  ray_rd,
    input  trace_types_pkg::ray_t                 ray,
    input  logic                                  result_almost_full,
    output logic [trace_cfg_pkg::TRI_ID_BITS-1:0] mem_addr,
    input  trace_types_pkg::triangle_t            mem_data,
    pair_if.src                                   pair
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    logic                    busy;
    logic [TRI_ID_BITS-1:0]  tri_cnt;
    logic                    last_addr;
    logic [RAY_ID_BITS-1:0]  ray_id_cnt;
    ray_t                    cur_ray;
    logic [RAY_ID_BITS-1:0]  cur_ray_id;
    logic                    issue_valid;
    logic                    issue_last;
    logic [TRI_ID_BITS-1:0]  issue_tri_id;

    assign last_addr = tri_cnt == TRI_ID_BITS'(NUM_TRI - 1);

    // headroom in the result queue covers the ray still in flight
    assign ray_rd   = !busy && !ray_empty && !result_almost_full;
    assign mem_addr = tri_cnt;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy        <= 1'b0;
            tri_cnt     <= '0;
            ray_id_cnt  <= '0;
            issue_valid <= 1'b0;
            issue_last  <= 1'b0;
        end else begin
            if (ray_rd) begin
                busy       <= 1'b1;
                ray_id_cnt <= ray_id_cnt + 1'b1;
            end else if (busy) begin
                tri_cnt <= last_addr ? '0 : tri_cnt + 1'b1;
                busy    <= !last_addr;
            end
            // one cycle behind the address, same as the memory data
            issue_valid <= busy;
            issue_last  <= busy && last_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (ray_rd) begin
            cur_ray    <= ray;
            cur_ray_id <= ray_id_cnt;
        end
        issue_tri_id <= tri_cnt;
    end

    // ray and id stay put until the old ray's last pair has gone out
    assign pair.valid    = issue_valid;
    assign pair.last     = issue_last;
    assign pair.ray_id   = cur_ray_id;
    assign pair.ray      = cur_ray;
    assign pair.tri_id   = issue_tri_id;
    assign pair.triangle = mem_data;

    a_last_with_valid: assert property (@(posedge clock) disable iff (reset)
        pair.last |-> pair.valid && pair.tri_id == TRI_ID_BITS'(NUM_TRI - 1));

    // popped ray shows up as pair 0 two cycles later
    a_first_pair: assert property (@(posedge clock) disable iff (reset)
        ray_rd |-> ##2 (pair.valid && pair.tri_id == '0));

endmodule

`default_nettype wire

// File: rtl/ray_tracer_top.sv
`default_nettype none

module ray_tracer_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  tri_wr,
    input  logic [trace_cfg_pkg::TRI_ID_BITS-1:0] tri_addr,
    input  trace_types_pkg::triangle_t            tri_data,
    input  logic                                  ray_wr,
    input  trace_types_pkg::ray_t                 ray_in,
    output logic                                  ray_full,
    input  logic                                  result_rd,
    output trace_types_pkg::result_t              result_out,
    output logic                                  result_empty
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    logic                    ray_rd;
    logic                    ray_empty;
    ray_t                    ray_q;
    logic [TRI_ID_BITS-1:0]  mem_addr;
    triangle_t               mem_data;
    logic                    result_wr;
    result_t                 result_d;
    logic                    result_almost_full;

    pair_if pair_bus ();
    hit_if  hit_bus ();

    ray_fifo #(
        .payload_t   (ray_t),
        .DEPTH       (RAY_FIFO_DEPTH)
    ) i_ray_fifo (
        .clock       (clock),
        .reset       (reset),
        .wr_en       (ray_wr),
        .din         (ray_in),
        .full        (ray_full),
        .almost_full (),
        .rd_en       (ray_rd),
        .dout        (ray_q),
        .empty       (ray_empty)
    );

    triangle_mem i_triangle_mem (
        .clock   (clock),
        .wr_en   (tri_wr),
        .wr_addr (tri_addr),
        .din     (tri_data),
        .rd_addr (mem_addr),
        .dout    (mem_data)
    );

    ray_streamer i_ray_streamer (
        .clock              (clock),
        .reset              (reset),
        .ray_empty          (ray_empty),
        .ray_rd             (ray_rd),
        .ray                (ray_q),
        .result_almost_full (result_almost_full),
        .mem_addr           (mem_addr),
        .mem_data           (mem_data),
        .pair               (pair_bus.src)
    );

    edge_hit_test i_edge_hit_test (
        .clock (clock),
        .reset (reset),
        .pair  (pair_bus.dst),
        .hit   (hit_bus.src)
    );

    hit_accumulate i_hit_accumulate (
        .clock     (clock),
        .reset     (reset),
        .hit       (hit_bus.dst),
        .result_wr (result_wr),
        .result    (result_d)
    );

    // full is never reached, the streamer throttles on almost_full
    ray_fifo #(
        .payload_t   (result_t),
        .DEPTH       (RESULT_FIFO_DEPTH)
    ) i_result_fifo (
        .clock       (clock),
        .reset       (reset),
        .wr_en       (result_wr),
        .din         (result_d),
        .full        (),
        .almost_full (result_almost_full),
        .rd_en       (result_rd),
        .dout        (result_out),
        .empty       (result_empty)
    );

endmodule

`default_nettype wire

// File: rtl/trace_cfg_pkg.sv
`default_nettype none

package trace_cfg_pkg;

    // coordinate and depth formats
    localparam int COORD_BITS = 12;
    localparam int DEPTH_BITS = 16;

    // triangle store
    localparam int NUM_TRI     = 16;
    localparam int TRI_ID_BITS = 4;

    // wrapping ray counter
    localparam int RAY_ID_BITS = 8;

    // queue depths
    localparam int RAY_FIFO_DEPTH    = 16;
    localparam int RESULT_FIFO_DEPTH = 8;

    // a single cross product fits here, the edge sum needs one bit more
    localparam int EDGE_BITS = 25;

endpackage

`default_nettype wire

// File: rtl/trace_if.sv
`default_nettype none

// one ray-triangle pair per valid strobe
interface pair_if;

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    logic                    valid;
    logic                    last;
    logic [RAY_ID_BITS-1:0]  ray_id;
    ray_t                    ray;
    logic [TRI_ID_BITS-1:0]  tri_id;
    triangle_t               triangle;

    modport src (output valid, output last, output ray_id, output ray, output tri_id,
                 output triangle);

    modport dst (input valid, input last, input ray_id, input ray, input tri_id,
                 input triangle);

endinterface

// coverage verdict for one pair
interface hit_if;

    import trace_cfg_pkg::*;

    logic                    valid;
    logic                    last;
    logic [RAY_ID_BITS-1:0]  ray_id;
    logic [TRI_ID_BITS-1:0]  tri_id;
    logic                    hit;
    logic [DEPTH_BITS-1:0]   depth;

    modport src (output valid, output last, output ray_id, output tri_id, output hit,
                 output depth);

    modport dst (input valid, input last, input ray_id, input tri_id, input hit,
                 input depth);

endinterface

`default_nettype wire

// File: rtl/trace_types_pkg.sv
`default_nettype none

package trace_types_pkg;

    import trace_cfg_pkg::*;

    // point in the image plane, ray travels along +z
    typedef struct packed {
        logic signed [COORD_BITS-1:0] x;
        logic signed [COORD_BITS-1:0] y;
    } ray_t;

    typedef struct packed {
        logic signed [COORD_BITS-1:0] x;
        logic signed [COORD_BITS-1:0] y;
    } vertex_t;

    // counter-clockwise winding, flat at one depth
    typedef struct packed {
        vertex_t                 v0;
        vertex_t                 v1;
        vertex_t                 v2;
        logic [DEPTH_BITS-1:0]   depth;
    } triangle_t;

    // tri_id and depth are zero on a miss
    typedef struct packed {
        logic [RAY_ID_BITS-1:0]  ray_id;
        logic                    hit;
        logic [TRI_ID_BITS-1:0]  tri_id;
        logic [DEPTH_BITS-1:0]   depth;
    } result_t;

endpackage

`default_nettype wire

// File: rtl/triangle_mem.sv
`default_nettype none

module triangle_mem (
    input  logic                                  clock,
    input  logic                                  wr_en,
    input  logic [trace_cfg_pkg::TRI_ID_BITS-1:0] wr_addr,
    input  trace_types_pkg::triangle_t            din,
    input  logic [trace_cfg_pkg::TRI_ID_BITS-1:0] rd_addr,
    output trace_types_pkg::triangle_t            dout
);

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    triangle_t mem [NUM_TRI];

    // contents come from host loads only
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= din;
        end
        dout <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: test/ray_tracer_tb.sv
`default_nettype none

module ray_tracer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import trace_cfg_pkg::*;
    import trace_types_pkg::*;

    // about 300 rays over all tests, read gaps stay below the per-ray time
    localparam int MAX_RAYS    = 340;
    localparam int CYCLE_LIMIT = MAX_RAYS * (NUM_TRI + 8) + 2000;

    logic                    clock;
    logic                    reset;
    logic                    tri_wr;
    logic [TRI_ID_BITS-1:0]  tri_addr;
    triangle_t               tri_data;
    logic                    ray_wr;
    ray_t                    ray_in;
    logic                    ray_full;
    logic                    result_rd;
    result_t                 result_out;
    logic                    result_empty;

    triangle_t               tri_model [NUM_TRI];
    logic [RAY_ID_BITS-1:0]  next_id;
    result_t                 exp_q [$];
    ray_t                    ray_q [$];
    logic [31:0]             lfsr;
    int                      cycles;

    ray_tracer_top i_ray_tracer_top (
        .clock        (clock),
        .reset        (reset),
        .tri_wr       (tri_wr),
        .tri_addr     (tri_addr),
        .tri_data     (tri_data),
        .ray_wr       (ray_wr),
        .ray_in       (ray_in),
        .ray_full     (ray_full),
        .result_rd    (result_rd),
        .result_out   (result_out),
        .result_empty (result_empty)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("simulation ran %0d cycles without finishing the tests", cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic signed [COORD_BITS-1:0] rand_coord();
        logic signed [7:0] b;
        b = 8'(rand_bits(8));
        return b;
    endfunction

    function automatic ray_t make_ray(input int x, input int y);
        ray_t r;
        r.x = COORD_BITS'(x);
        r.y = COORD_BITS'(y);
        return r;
    endfunction

    function automatic triangle_t make_tri(input int x0, input int y0, input int x1,
                                           input int y1, input int x2, input int y2,
                                           input int depth);
        triangle_t t;
        t.v0    = make_ray(x0, y0);
        t.v1    = make_ray(x1, y1);
        t.v2    = make_ray(x2, y2);
        t.depth = DEPTH_BITS'(depth);
        return t;
    endfunction

    // cross product of a->b with a->p
    function automatic int edge_val(vertex_t a, vertex_t b, ray_t p);
        return (int'(b.x) - int'(a.x)) * (int'(p.y) - int'(a.y)) -
               (int'(b.y) - int'(a.y)) * (int'(p.x) - int'(a.x));
    endfunction

    function automatic bit covers(triangle_t t, ray_t p);
        return edge_val(t.v0, t.v1, p) >= 0 && edge_val(t.v1, t.v2, p) >= 0 &&
               edge_val(t.v2, t.v0, p) >= 0;
    endfunction

    // nearest covering triangle, first index kept on equal depth
    function automatic result_t expected_result(ray_t p);
        result_t r;
        r        = '0;
        r.ray_id = next_id;
        for (int k = 0; k < NUM_TRI; k++) begin
            if (covers(tri_model[k], p) && (!r.hit || tri_model[k].depth < r.depth)) begin
                r.hit    = 1'b1;
                r.tri_id = TRI_ID_BITS'(k);
                r.depth  = tri_model[k].depth;
            end
        end
        return r;
    endfunction

    function automatic triangle_t random_tri();
        triangle_t t;
        vertex_t   v;
        t.v0    = make_ray(rand_coord(), rand_coord());
        t.v1    = make_ray(rand_coord(), rand_coord());
        t.v2    = make_ray(rand_coord(), rand_coord());
        t.depth = DEPTH_BITS'(rand_bits(3));
        // flip clockwise ones
        if (edge_val(t.v0, t.v1, ray_t'(t.v2)) < 0) begin
            v    = t.v1;
            t.v1 = t.v2;
            t.v2 = v;
        end
        return t;
    endfunction

    task automatic load_tri(input int addr, input triangle_t t);
        @(posedge clock);
        tri_wr          <= 1'b1;
        tri_addr        <= TRI_ID_BITS'(addr);
        tri_data        <= t;
        tri_model[addr]  = t;
        @(posedge clock);
        tri_wr <= 1'b0;
    endtask

    // clockwise filler has negative area, so it covers no point
    task automatic load_filler();
        for (int k = 0; k < NUM_TRI; k++) begin
            load_tri(k, make_tri(0, 0, 0, 1, 1, 0, 16'hffff));
        end
    endtask

    task automatic push_ray(input ray_t r);
        @(negedge clock);
        while (ray_full) begin
            @(negedge clock);
        end
        exp_q.push_back(expected_result(r));
        next_id = next_id + 1'b1;
        @(posedge clock);
        ray_wr <= 1'b1;
        ray_in <= r;
        @(posedge clock);
        ray_wr <= 1'b0;
    endtask

    task automatic pop_and_check();
        result_t got;
        result_t exp;
        @(negedge clock);
        while (result_empty) begin
            @(negedge clock);
        end
        got = result_out;
        if (exp_q.size() == 0) begin
            $display("a result came out with no ray left to match it");
            abort_run();
        end
        exp = exp_q.pop_front();
        check_value("result_out.ray_id", got.ray_id, exp.ray_id);
        check_value("result_out.hit", got.hit, exp.hit);
        check_value("result_out.tri_id", got.tri_id, exp.tri_id);
        check_value("result_out.depth", got.depth, exp.depth);
        @(posedge clock);
        result_rd <= 1'b1;
        @(posedge clock);
        result_rd <= 1'b0;
    endtask

    task automatic run_stream(input bit gaps);
        int n;
        n = ray_q.size();
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    push_ray(ray_q[i]);
                end
            end
            begin
                for (int i = 0; i < n; i++) begin
                    if (gaps) begin
                        repeat (rand_bits(3)) @(posedge clock);
                    end
                    pop_and_check();
                end
            end
        join
        ray_q.delete();
    endtask

    task automatic test_single_hit();
        load_filler();
        load_tri(5, make_tri(0, 0, 100, 0, 0, 100, 16'h1234));
        ray_q.push_back(make_ray(10, 10));
        ray_q.push_back(make_ray(99, 1));
        run_stream(1'b0);
    endtask

    task automatic test_nearest_depth();
        load_filler();
        load_tri(2, make_tri(-200, -200, 200, -200, 0, 200, 300));
        load_tri(7, make_tri(-50, -50, 50, -50, 0, 50, 200));
        // same shape and depth as slot 7, loses the tie
        load_tri(9, make_tri(-50, -50, 50, -50, 0, 50, 200));
        load_tri(11, make_tri(-100, -100, 100, -100, 0, 100, 250));
        ray_q.push_back(make_ray(0, 0));
        ray_q.push_back(make_ray(0, -90));
        ray_q.push_back(make_ray(150, -150));
        run_stream(1'b0);
    endtask

    task automatic test_miss_and_edge();
        load_filler();
        load_tri(0, make_tri(0, 0, 64, 0, 0, 64, 77));
        ray_q.push_back(make_ray(500, 500));
        ray_q.push_back(make_ray(-1, 0));
        ray_q.push_back(make_ray(-2048, 2047));
        ray_q.push_back(make_ray(32, 0));
        ray_q.push_back(make_ray(0, 0));
        ray_q.push_back(make_ray(32, 32));
        run_stream(1'b0);
    endtask

    task automatic test_random_stream();
        int lead;
        for (int k = 0; k < NUM_TRI; k++) begin
            load_tri(k, random_tri());
        end
        // leading rays put the 40 checked ones across the id wrap
        lead = (2 ** RAY_ID_BITS - 20 - int'(next_id)) % (2 ** RAY_ID_BITS);
        for (int i = 0; i < lead + 40; i++) begin
            ray_q.push_back(make_ray(rand_coord(), rand_coord()));
        end
        run_stream(1'b1);
    endtask

    task automatic test_back_pressure();
        int pushed;
        int stalled;
        pushed  = 0;
        stalled = 0;
        // no result is read, so the result queue fills and the streamer stops
        while (stalled < 4 * NUM_TRI && pushed < 3 * RAY_FIFO_DEPTH) begin
            @(negedge clock);
            if (ray_full) begin
                stalled++;
            end else begin
                stalled = 0;
                push_ray(make_ray(rand_coord(), rand_coord()));
                pushed++;
            end
        end
        if (stalled < 4 * NUM_TRI) begin
            $display("ray_full did not stay high with %0d rays pushed and none read", pushed);
            abort_run();
        end
        check_value("result_empty", result_empty, 0);
        for (int i = 0; i < pushed; i++) begin
            pop_and_check();
        end
        repeat (4 * NUM_TRI) @(posedge clock);
        @(negedge clock);
        check_value("result_empty", result_empty, 1);
        check_value("ray_full", ray_full, 0);
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        tri_wr    = 1'b0;
        tri_addr  = '0;
        tri_data  = '0;
        ray_wr    = 1'b0;
        ray_in    = '0;
        result_rd = 1'b0;
        next_id   = '0;
        lfsr      = 32'h2fed_8ebf;
        cycles    = 0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("ray_full", ray_full, 0);
        check_value("result_empty", result_empty, 1);
        test_single_hit();
        test_nearest_depth();
        test_miss_and_edge();
        test_random_stream();
        test_back_pressure();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
